// File: cnn_rx_pkg.sv
// Shared data types, receiver state enum and class constants for the CNN receive path
package cnn_rx_pkg;

    // Word widths on the receive path
    localparam int ACC_W  = 18;
    localparam int BIAS_W = 16;
    localparam int PIX_W  = 16;
    localparam int IDX_W  = 4;

    // Signed MAC accumulator result from the array
    typedef logic signed [ACC_W-1:0] acc_t;

    // Signed bias word from the bias memory
    typedef logic signed [BIAS_W-1:0] bias_t;

    // Unsigned activation after ReLU, also the pooled pixel
    typedef logic [PIX_W-1:0] pix_t;

    // Signed class score, same width as a bias
    typedef logic signed [BIAS_W-1:0] score_t;

    // Class index, wide enough for ten classes
    typedef logic [IDX_W-1:0] class_idx_t;

    // Bias memory address, 16 words deep
    typedef logic [IDX_W-1:0] bias_addr_t;

    // Compare tree below is built for exactly this many scores
    localparam int NUM_CLASSES = 10;

    // Bias memory map
    // Word 0 holds the conv layer bias
    localparam bias_addr_t CONV_BIAS_ADDR = 4'd0;
    // Class biases follow at 1..10
    localparam bias_addr_t SCORE_BIAS_BASE = 4'd1;

    // Receive FSM
    typedef enum logic [1:0] {
        CONV_PROCESS,
        CLASS_PROCESS,
        CLASSIFY
    } rx_state_t;

endpackage

// File: rx_sequencer.sv
// Receive FSM with raster counters, score counter, bias address select and pooling strobes
`timescale 1ns/1ps

module rx_sequencer #(
    parameter int FMAP_W = 8,
    parameter int FMAP_H = 8,
    localparam int POOL_AW = $clog2((FMAP_W / 2) * (FMAP_H / 2))
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   acc_valid_i,
    output logic                   acc_ready_o,
    output cnn_rx_pkg::bias_addr_t bias_addr_o,
    output logic                   conv_push_o,
    output logic                   pool_fire_o,
    output logic [POOL_AW-1:0]     pool_addr_o,
    output logic                   score_push_o,
    output cnn_rx_pkg::class_idx_t score_idx_o,
    output logic                   classify_start_o
);
    import cnn_rx_pkg::*;

    localparam int XW = $clog2(FMAP_W);
    localparam int YW = $clog2(FMAP_H);

    rx_state_t     state;
    logic [XW-1:0] x_cnt;
    logic [YW-1:0] y_cnt;
    class_idx_t    score_cnt;
    logic          accept;
    logic          last_x;
    logic          last_y;
    logic          last_score;

    // Only the single CLASSIFY cycle refuses a result
    assign acc_ready_o = (state != CLASSIFY);
    assign accept      = acc_valid_i && acc_ready_o;

    assign last_x     = (x_cnt == XW'(FMAP_W - 1));
    assign last_y     = (y_cnt == YW'(FMAP_H - 1));
    assign last_score = (score_cnt == class_idx_t'(NUM_CLASSES - 1));

    // Push strobes already carry the accept
    assign conv_push_o  = accept && (state == CONV_PROCESS);
    assign score_push_o = accept && (state == CLASS_PROCESS);
    assign score_idx_o  = score_cnt;

    assign classify_start_o = (state == CLASSIFY);

    // Odd x and odd y close a 2x2 window
    assign pool_fire_o = conv_push_o && x_cnt[0] && y_cnt[0];
    // Half-row times pooled row length plus half-column
    assign pool_addr_o = POOL_AW'((y_cnt >> 1) * (FMAP_W / 2) + (x_cnt >> 1));

    // Bias memory is read combinationally, so the address follows the current beat
    always_comb
    begin
        bias_addr_o = CONV_BIAS_ADDR;
        if (state == CLASS_PROCESS)
        begin
            bias_addr_o = SCORE_BIAS_BASE + score_cnt;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state     <= CONV_PROCESS;
            x_cnt     <= '0;
            y_cnt     <= '0;
            score_cnt <= '0;
        end
        else
        begin
            case (state)
                CONV_PROCESS:
                begin
                    if (accept)
                    begin
                        // Raster walk, x fastest
                        if (last_x)
                        begin
                            x_cnt <= '0;
                            if (last_y)
                            begin
                                y_cnt <= '0;
                                state <= CLASS_PROCESS;
                            end
                            else
                            begin
                                y_cnt <= y_cnt + 1'b1;
                            end
                        end
                        else
                        begin
                            x_cnt <= x_cnt + 1'b1;
                        end
                    end
                end
                CLASS_PROCESS:
                begin
                    if (accept)
                    begin
                        if (last_score)
                        begin
                            score_cnt <= '0;
                            state     <= CLASSIFY;
                        end
                        else
                        begin
                            score_cnt <= score_cnt + 1'b1;
                        end
                    end
                end
                CLASSIFY:
                begin
                    // One cycle only, then a fresh frame
                    x_cnt     <= '0;
                    y_cnt     <= '0;
                    score_cnt <= '0;
                    state     <= CONV_PROCESS;
                end
                default:
                begin
                    state <= CONV_PROCESS;
                end
            endcase
        end
    end

endmodule

// File: pool_window.sv
// Bias add with ReLU, two-row line buffer and 2x2 average pooling with registered fmap write
`timescale 1ns/1ps

module pool_window #(
    parameter int FMAP_W = 8,
    parameter int FMAP_H = 8,
    localparam int POOL_AW = $clog2((FMAP_W / 2) * (FMAP_H / 2))
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               conv_push_i,
    input  logic               pool_fire_i,
    input  logic [POOL_AW-1:0] pool_addr_i,
    input  cnn_rx_pkg::acc_t   acc_data_i,
    input  cnn_rx_pkg::bias_t  bias_data_i,
    output logic               fmap_wr_en_o,
    output logic [POOL_AW-1:0] fmap_wr_addr_o,
    output cnn_rx_pkg::pix_t   fmap_wr_data_o
);
    import cnn_rx_pkg::*;

    acc_t        biased;
    pix_t        act;
    logic [17:0] win_sum;

    // Entry 0 is the previous pixel, entry FMAP_W the one above and left
    pix_t line_buf [FMAP_W+1];

    // Sign-extend the 16-bit bias to the accumulator width
    assign biased = acc_data_i + {{2{bias_data_i[15]}}, bias_data_i};

    // ReLU, negative results clamp to zero
    assign act = biased[17] ? '0 : biased[15:0];

    // Current pixel, left neighbour, and the two pixels one row up
    assign win_sum = 18'(act) + 18'(line_buf[0]) + 18'(line_buf[FMAP_W-1])
                   + 18'(line_buf[FMAP_W]);

    // Shift register advances only on accepted conv results
    always_ff @(posedge clk)
    begin
        if (conv_push_i)
        begin
            line_buf[0] <= act;
            for (int i = 1; i <= FMAP_W; i++)
            begin
                line_buf[i] <= line_buf[i-1];
            end
        end
    end

    // Write strobe one cycle after the window closes
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            fmap_wr_en_o <= 1'b0;
        end
        else
        begin
            fmap_wr_en_o <= pool_fire_i;
        end
    end

    // Average by four, truncating
    always_ff @(posedge clk)
    begin
        if (pool_fire_i)
        begin
            fmap_wr_addr_o <= pool_addr_i;
            fmap_wr_data_o <= win_sum[17:2];
        end
    end

endmodule

// File: score_bank.sv
// Bias-corrected class score registers
`timescale 1ns/1ps

module score_bank (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   score_push_i,
    input  cnn_rx_pkg::class_idx_t score_idx_i,
    input  cnn_rx_pkg::acc_t       acc_data_i,
    input  cnn_rx_pkg::bias_t      bias_data_i,
    output cnn_rx_pkg::score_t     scores_o [cnn_rx_pkg::NUM_CLASSES]
);
    import cnn_rx_pkg::*;

    score_t new_score;

    // Low 16 bits of the result plus bias, wraps on overflow
    assign new_score = score_t'(acc_data_i[15:0] + bias_data_i);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int i = 0; i < NUM_CLASSES; i++)
            begin
                scores_o[i] <= '0;
            end
        end
        else
        begin
            // One slot per push, previous frame's value is simply overwritten
            for (int i = 0; i < NUM_CLASSES; i++)
            begin
                if (score_push_i && (score_idx_i == class_idx_t'(i)))
                begin
                    scores_o[i] <= new_score;
                end
            end
        end
    end

endmodule

// File: argmax_pipe.sv
// Four-stage pipelined argmax over the ten class scores
`timescale 1ns/1ps

module argmax_pipe (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  cnn_rx_pkg::score_t     scores_i [cnn_rx_pkg::NUM_CLASSES],
    output cnn_rx_pkg::class_idx_t digit_o,
    output logic                   digit_valid_o
);
    import cnn_rx_pkg::*;

    localparam int NUM_PAIRS = NUM_CLASSES / 2;

    // Stage 1, five pair winners
    logic       s1_valid;
    class_idx_t s1_idx [NUM_PAIRS];
    score_t     s1_val [NUM_PAIRS];

    // Stage 2, two winners plus the fifth pair riding along
    logic       s2_valid;
    class_idx_t s2_idx [2];
    score_t     s2_val [2];
    class_idx_t s2_tail_idx;
    score_t     s2_tail_val;

    // Stage 3
    logic       s3_valid;
    class_idx_t s3_idx;
    score_t     s3_val;
    class_idx_t s3_tail_idx;
    score_t     s3_tail_val;

    // Valid bit walks alongside the data
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            s1_valid      <= 1'b0;
            s2_valid      <= 1'b0;
            s3_valid      <= 1'b0;
            digit_valid_o <= 1'b0;
        end
        else
        begin
            s1_valid      <= start_i;
            s2_valid      <= s1_valid;
            s3_valid      <= s2_valid;
            digit_valid_o <= s3_valid;
        end
    end

    // Values travel with indices so later stages never look back at the score bank
    // Ties go to the second operand
    always_ff @(posedge clk)
    begin
        for (int p = 0; p < NUM_PAIRS; p++)
        begin
            if (scores_i[2*p] > scores_i[2*p+1])
            begin
                s1_idx[p] <= class_idx_t'(2 * p);
                s1_val[p] <= scores_i[2*p];
            end
            else
            begin
                s1_idx[p] <= class_idx_t'(2 * p + 1);
                s1_val[p] <= scores_i[2*p+1];
            end
        end

        for (int q = 0; q < 2; q++)
        begin
            if (s1_val[2*q] > s1_val[2*q+1])
            begin
                s2_idx[q] <= s1_idx[2*q];
                s2_val[q] <= s1_val[2*q];
            end
            else
            begin
                s2_idx[q] <= s1_idx[2*q+1];
                s2_val[q] <= s1_val[2*q+1];
            end
        end
        s2_tail_idx <= s1_idx[NUM_PAIRS-1];
        s2_tail_val <= s1_val[NUM_PAIRS-1];

        if (s2_val[0] > s2_val[1])
        begin
            s3_idx <= s2_idx[0];
            s3_val <= s2_val[0];
        end
        else
        begin
            s3_idx <= s2_idx[1];
            s3_val <= s2_val[1];
        end
        s3_tail_idx <= s2_tail_idx;
        s3_tail_val <= s2_tail_val;

        // Final round against the fifth pair's winner
        digit_o <= (s3_val > s3_tail_val) ? s3_idx : s3_tail_idx;
    end

endmodule

// File: cnn_rx_top.sv
// Receive path top level connecting sequencer, pooling unit, score bank and argmax pipeline
`timescale 1ns/1ps

module cnn_rx_top #(
    parameter int FMAP_W = 8,
    parameter int FMAP_H = 8,
    localparam int POOL_AW = $clog2((FMAP_W / 2) * (FMAP_H / 2))
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   acc_valid_i,
    input  cnn_rx_pkg::acc_t       acc_data_i,
    output logic                   acc_ready_o,
    output cnn_rx_pkg::bias_addr_t bias_addr_o,
    input  cnn_rx_pkg::bias_t      bias_data_i,
    output logic                   fmap_wr_en_o,
    output logic [POOL_AW-1:0]     fmap_wr_addr_o,
    output cnn_rx_pkg::pix_t       fmap_wr_data_o,
    output cnn_rx_pkg::class_idx_t digit_o,
    output logic                   digit_valid_o
);
    import cnn_rx_pkg::*;

    logic               conv_push;
    logic               pool_fire;
    logic [POOL_AW-1:0] pool_addr;
    logic               score_push;
    class_idx_t         score_idx;
    logic               classify_start;
    score_t             scores [NUM_CLASSES];

    // Frame control and bias addressing
    rx_sequencer #(
        .FMAP_W (FMAP_W),
        .FMAP_H (FMAP_H)
    ) seq_i (
        .clk              (clk),
        .rst              (rst),
        .acc_valid_i      (acc_valid_i),
        .acc_ready_o      (acc_ready_o),
        .bias_addr_o      (bias_addr_o),
        .conv_push_o      (conv_push),
        .pool_fire_o      (pool_fire),
        .pool_addr_o      (pool_addr),
        .score_push_o     (score_push),
        .score_idx_o      (score_idx),
        .classify_start_o (classify_start)
    );

    // Conv phase datapath
    pool_window #(
        .FMAP_W (FMAP_W),
        .FMAP_H (FMAP_H)
    ) pool_i (
        .clk            (clk),
        .rst            (rst),
        .conv_push_i    (conv_push),
        .pool_fire_i    (pool_fire),
        .pool_addr_i    (pool_addr),
        .acc_data_i     (acc_data_i),
        .bias_data_i    (bias_data_i),
        .fmap_wr_en_o   (fmap_wr_en_o),
        .fmap_wr_addr_o (fmap_wr_addr_o),
        .fmap_wr_data_o (fmap_wr_data_o)
    );

    // Classification phase
    score_bank score_i (
        .clk          (clk),
        .rst          (rst),
        .score_push_i (score_push),
        .score_idx_i  (score_idx),
        .acc_data_i   (acc_data_i),
        .bias_data_i  (bias_data_i),
        .scores_o     (scores)
    );

    argmax_pipe argmax_i (
        .clk           (clk),
        .rst           (rst),
        .start_i       (classify_start),
        .scores_i      (scores),
        .digit_o       (digit_o),
        .digit_valid_o (digit_valid_o)
    );

endmodule

// File: tb_clkgen.sv
// Testbench clock generator, free-running clock with a fixed period
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    // Starts low so the first rising edge lands half a period in
    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2);
            clk_o = ~clk_o;
        end
    end

endmodule

// File: cnn_rx_checker.sv
// Concurrent protocol assertions for the CNN receive path top level
`timescale 1ns/1ps

module cnn_rx_checker (
    input logic clk,
    input logic rst,
    input logic acc_valid_i,
    input logic acc_ready_i,
    input logic fmap_wr_en_i,
    input logic digit_valid_i
);

    // One digit per frame, a single-cycle pulse
    property digit_pulse_single;
        @(posedge clk) disable iff (!rst)
        digit_valid_i |=> !digit_valid_i;
    endproperty

    // Every pooled write follows an accepted conv result
    property fmap_write_after_accept;
        @(posedge clk) disable iff (!rst)
        fmap_wr_en_i |-> $past(acc_valid_i && acc_ready_i);
    endproperty

    // Ready drops only for the CLASSIFY cycle
    property ready_low_single;
        @(posedge clk) disable iff (!rst)
        !acc_ready_i |=> acc_ready_i;
    endproperty

    digit_pulse_a : assert property (digit_pulse_single)
        else $error("digit_valid_o stayed high for two cycles");

    fmap_write_a : assert property (fmap_write_after_accept)
        else $error("fmap_wr_en_o high without an accepted result in the previous cycle");

    ready_low_a : assert property (ready_low_single)
        else $error("acc_ready_o stayed low for two cycles");

endmodule

// File: cnn_rx_tb.sv
// Testbench top with bias memory model, frame stimulus, reference model, compare and watchdog
`timescale 1ns/1ps

module cnn_rx_tb;
    import cnn_rx_pkg::*;

    localparam int FMAP_W          = 8;
    localparam int FMAP_H          = 8;
    localparam int POOL_AW         = $clog2((FMAP_W / 2) * (FMAP_H / 2));
    localparam int NUM_FRAMES      = 5;
    localparam int FRAME_BEATS     = FMAP_W * FMAP_H + NUM_CLASSES;
    localparam int WATCHDOG_CYCLES = 20 * NUM_FRAMES * FRAME_BEATS + 200;
    localparam logic [31:0] SEED   = 32'h87f05493;

    logic               clk;
    logic               rst;
    logic               acc_valid_i;
    acc_t               acc_data_i;
    logic               acc_ready_o;
    bias_addr_t         bias_addr_o;
    bias_t              bias_data_i;
    logic               fmap_wr_en_o;
    logic [POOL_AW-1:0] fmap_wr_addr_o;
    pix_t               fmap_wr_data_o;
    class_idx_t         digit_o;
    logic               digit_valid_o;

    // Bias memory answers the address in the same cycle
    bias_t bias_mem [16];

    // Expected writes and digits with the cycle each one is due
    logic [POOL_AW-1:0] exp_addr_q [$];
    pix_t               exp_pix_q [$];
    int                 exp_wcyc_q [$];
    class_idx_t         exp_digit_q [$];
    int                 exp_dcyc_q [$];

    int cyc;
    bit run_done;
    bit fail_seen;

    tb_clkgen #(.PERIOD_NS(4)) clkgen_i (.clk_o(clk));

    cnn_rx_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .acc_valid_i    (acc_valid_i),
        .acc_data_i     (acc_data_i),
        .acc_ready_o    (acc_ready_o),
        .bias_addr_o    (bias_addr_o),
        .bias_data_i    (bias_data_i),
        .fmap_wr_en_o   (fmap_wr_en_o),
        .fmap_wr_addr_o (fmap_wr_addr_o),
        .fmap_wr_data_o (fmap_wr_data_o),
        .digit_o        (digit_o),
        .digit_valid_o  (digit_valid_o)
    );

    bind cnn_rx_top cnn_rx_checker chk_i (
        .clk           (clk),
        .rst           (rst),
        .acc_valid_i   (acc_valid_i),
        .acc_ready_i   (acc_ready_o),
        .fmap_wr_en_i  (fmap_wr_en_o),
        .digit_valid_i (digit_valid_o)
    );

    assign bias_data_i = bias_mem[bias_addr_o];

    // Edge counter that edge k sets to k
    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        fail_seen = 1'b1;
        $display("Regression failed");
        $fatal(1, "stopping at first failure");
    endtask

    // Activation is the biased result with negatives at zero and the low 16 bits kept
    function automatic pix_t relu_act(input acc_t acc, input bias_t bias);
        int v;
        v = int'(acc) + int'(bias);
        return (v < 0) ? pix_t'(0) : pix_t'(v);
    endfunction

    // Truncating mean of the four window pixels
    function automatic pix_t pool_pixel(input pix_t a, input pix_t b, input pix_t c,
                                        input pix_t d);
        int s;
        s = int'(a) + int'(b) + int'(c) + int'(d);
        return pix_t'(s / 4);
    endfunction

    // Score wraps at 16 bits
    function automatic score_t score_of(input acc_t acc, input bias_t bias);
        return score_t'(int'(acc) + int'(bias));
    endfunction

    function automatic class_idx_t argmax_of(input score_t s [NUM_CLASSES]);
        int best;
        best = 0;
        for (int i = 1; i < NUM_CLASSES; i++)
        begin
            if (s[i] > s[best])
                best = i;
        end
        return class_idx_t'(best);
    endfunction

    task automatic check_pix(input logic [POOL_AW-1:0] exp_addr,
                             input logic [POOL_AW-1:0] act_addr,
                             input pix_t exp_data, input pix_t act_data);
        if (exp_addr !== act_addr)
            fail_run($sformatf("mismatch at %0d ns: fmap_wr_addr_o expected %0d actual %0d",
                               $time, exp_addr, act_addr));
        else if (exp_data !== act_data)
            fail_run($sformatf("mismatch at %0d ns: fmap_wr_data_o expected %0d actual %0d",
                               $time, exp_data, act_data));
    endtask

    task automatic check_digit(input class_idx_t exp_digit, input class_idx_t act_digit);
        if (exp_digit !== act_digit)
            fail_run($sformatf("mismatch at %0d ns: digit_o expected %0d actual %0d",
                               $time, exp_digit, act_digit));
    endtask

    // Offer one beat and return once it is taken, optionally after idle gaps
    task automatic send_beat(input acc_t data, input bit gaps, output int accept_cyc);
        logic taken;
        while (gaps && ($urandom_range(0, 3) == 0))
        begin
            acc_valid_i = 1'b0;
            acc_data_i  = acc_t'($urandom);
            @(posedge clk);
            #1;
        end
        acc_valid_i = 1'b1;
        acc_data_i  = data;
        // Ready is stable at the falling edge ahead of the accepting edge
        do
        begin
            @(negedge clk);
            taken = acc_ready_o;
            @(posedge clk);
            #1;
        end
        while (!taken);
        accept_cyc = cyc;
    endtask

    task automatic run_frame(input bit clamp, input bit gaps);
        acc_t   conv_in [FMAP_W * FMAP_H];
        pix_t   act [FMAP_W * FMAP_H];
        acc_t   score_in [NUM_CLASSES];
        score_t ref_score [NUM_CLASSES];
        bit     distinct;
        int     acc_cyc;
        int     p;
        // Previous frame no longer reads the bias memory here
        if (clamp)
            bias_mem[0] = bias_t'(-int'($urandom_range(0, 500)));
        else
            bias_mem[0] = bias_t'(int'($urandom_range(0, 1000)) - 500);
        for (int i = 0; i < NUM_CLASSES; i++)
            bias_mem[i + 1] = bias_t'($urandom);
        for (int i = 0; i < FMAP_W * FMAP_H; i++)
        begin
            if (clamp)
                conv_in[i] = acc_t'(-int'($urandom_range(1000, 3000)));
            else
                conv_in[i] = acc_t'(int'($urandom_range(0, 4000)) - 2000);
            act[i] = relu_act(conv_in[i], bias_mem[0]);
        end
        // Redraw until all ten corrected scores differ
        do
        begin
            for (int i = 0; i < NUM_CLASSES; i++)
            begin
                score_in[i]  = acc_t'($urandom);
                ref_score[i] = score_of(score_in[i], bias_mem[i + 1]);
            end
            distinct = 1'b1;
            for (int i = 0; i < NUM_CLASSES; i++)
                for (int j = i + 1; j < NUM_CLASSES; j++)
                    if (ref_score[i] == ref_score[j])
                        distinct = 1'b0;
        end
        while (!distinct);
        for (int y = 0; y < FMAP_H; y++)
        begin
            for (int x = 0; x < FMAP_W; x++)
            begin
                p = y * FMAP_W + x;
                send_beat(conv_in[p], gaps, acc_cyc);
                if ((x % 2 == 1) && (y % 2 == 1))
                begin
                    exp_addr_q.push_back(POOL_AW'((y / 2) * (FMAP_W / 2) + x / 2));
                    exp_pix_q.push_back(pool_pixel(act[p - FMAP_W - 1], act[p - FMAP_W],
                                                   act[p - 1], act[p]));
                    exp_wcyc_q.push_back(acc_cyc);
                end
            end
        end
        for (int i = 0; i < NUM_CLASSES; i++)
            send_beat(score_in[i], gaps, acc_cyc);
        // Digit is due four edges after the last score
        exp_digit_q.push_back(argmax_of(ref_score));
        exp_dcyc_q.push_back(acc_cyc + 4);
    endtask

    task automatic check_reset_state();
        repeat (3)
        begin
            @(negedge clk);
            if (acc_ready_o !== 1'b1)
                fail_run($sformatf("mismatch at %0d ns: acc_ready_o expected 1 actual %b",
                                   $time, acc_ready_o));
            if (fmap_wr_en_o !== 1'b0)
                fail_run($sformatf("mismatch at %0d ns: fmap_wr_en_o expected 0 actual %b",
                                   $time, fmap_wr_en_o));
            if (digit_valid_o !== 1'b0)
                fail_run($sformatf("mismatch at %0d ns: digit_valid_o expected 0 actual %b",
                                   $time, digit_valid_o));
        end
        @(posedge clk);
        #1;
    endtask

    // Compare process samples outputs mid-cycle
    always @(negedge clk)
    begin
        if (rst)
        begin
            if (fmap_wr_en_o)
            begin
                if (exp_wcyc_q.size() == 0 || exp_wcyc_q[0] != cyc)
                    fail_run($sformatf("fmap write at %0d ns was not expected in this cycle",
                                       $time));
                else
                begin
                    check_pix(exp_addr_q.pop_front(), fmap_wr_addr_o,
                              exp_pix_q.pop_front(), fmap_wr_data_o);
                    void'(exp_wcyc_q.pop_front());
                end
            end
            else if (exp_wcyc_q.size() != 0 && exp_wcyc_q[0] == cyc)
                fail_run($sformatf("expected fmap write missing at %0d ns", $time));
            if (digit_valid_o)
            begin
                if (exp_dcyc_q.size() == 0 || exp_dcyc_q[0] != cyc)
                    fail_run($sformatf("digit_valid_o pulsed at %0d ns outside its cycle",
                                       $time));
                else
                begin
                    check_digit(exp_digit_q.pop_front(), digit_o);
                    void'(exp_dcyc_q.pop_front());
                end
            end
            else if (exp_dcyc_q.size() != 0 && exp_dcyc_q[0] == cyc)
                fail_run($sformatf("expected digit_valid_o missing at %0d ns", $time));
        end
    end

    // Watchdog sized from the total number of beats
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run($sformatf("timeout: run still busy after %0d cycles, DUT appears hung",
                           WATCHDOG_CYCLES));
    end

    initial
    begin
        rst         = 1'b0;
        acc_valid_i = 1'b0;
        acc_data_i  = '0;
        cyc         = 0;
        run_done    = 1'b0;
        fail_seen   = 1'b0;
        void'($urandom(SEED));
        for (int i = 0; i < 16; i++)
            bias_mem[i] = bias_t'($urandom);
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;
        check_reset_state();
        // Plain pooling, then an all-negative frame, then gapped back-to-back frames
        run_frame(1'b0, 1'b0);
        run_frame(1'b1, 1'b0);
        run_frame(1'b0, 1'b1);
        run_frame(1'b0, 1'b1);
        run_frame(1'b0, 1'b1);
        acc_valid_i = 1'b0;
        // Last digit lands four edges after the last score
        repeat (8) @(posedge clk);
        if (exp_wcyc_q.size() == 0 && exp_dcyc_q.size() == 0)
        begin
            run_done = 1'b1;
            $display("Regression passed");
            $finish;
        end
        else
            fail_run("expected fmap writes or digits never appeared");
    end

    // Run stopped by an assertion or the simulator
    final
    begin
        if (!run_done && !fail_seen)
            $display("Regression failed");
    end

endmodule

// File: build.f
cnn_rx_pkg.sv
rx_sequencer.sv
pool_window.sv
score_bank.sv
argmax_pipe.sv
cnn_rx_top.sv
tb_clkgen.sv
cnn_rx_checker.sv
cnn_rx_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= cnn_rx_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
